// File: logic/bimodal_predictor.sv
module bimodal_predictor import bpu_pkg::*; #(
    parameter int BM_INDEX_BITS = 9
) (
    input  logic  clk,
    input  logic  rst,
    input  addr_t rd_pc_i,
    output logic  pdt_taken_o,
    input  logic  upd_i,
    input  logic  upd_taken_i,
    input  addr_t upd_pc_i
);

    localparam int ENTRIES = 1 << BM_INDEX_BITS;

    ctr_t                     ctr_q [ENTRIES];
    logic [BM_INDEX_BITS-1:0] rd_idx;
    logic [BM_INDEX_BITS-1:0] upd_idx;
    ctr_t                     upd_ctr;

    // halfword aligned so bit 0 is skipped
    assign rd_idx  = rd_pc_i[BM_INDEX_BITS:1];
    assign upd_idx = upd_pc_i[BM_INDEX_BITS:1];

    assign pdt_taken_o = ctr_q[rd_idx][1]; // msb is the direction

    // one saturating step toward the outcome
    always_comb begin
        upd_ctr = ctr_q[upd_idx];
        if (upd_taken_i) begin
            if (upd_ctr != 2'b11) begin
                upd_ctr = upd_ctr + 2'd1;
            end
        end else begin
            if (upd_ctr != 2'b00) begin
                upd_ctr = upd_ctr - 2'd1;
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < ENTRIES; i++) begin
                ctr_q[i] <= CTR_WEAK_NT;
            end
        end else if (upd_i) begin
            ctr_q[upd_idx] <= upd_ctr;
        end
    end

endmodule

// File: logic/bpu_pkg.sv
package bpu_pkg;

    localparam int XLEN = 32;

    typedef logic [XLEN-1:0] addr_t;

    // rv32 control-flow opcodes
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_JALR   = 7'b1100111;

    // link registers ra and t0
    localparam logic [4:0] REG_RA = 5'd1;
    localparam logic [4:0] REG_T0 = 5'd5;

    typedef struct packed {
        logic       imm12;    // sign bit
        logic [5:0] imm10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm4_1;
        logic       imm11;
        logic [6:0] opcode;
    } b_fmt_t;

    typedef struct packed {
        logic       imm20;    // sign bit
        logic [9:0] imm10_1;
        logic       imm11;
        logic [7:0] imm19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } j_fmt_t;

    typedef struct packed {
        logic [11:0] imm12;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    // same word seen through three layouts
    typedef union packed {
        b_fmt_t b_fmt;
        j_fmt_t j_fmt;
        i_fmt_t i_fmt;
    } inst_u;

    typedef logic [1:0] ctr_t;

    localparam ctr_t CTR_WEAK_NT = 2'b01;

endpackage

// File: logic/bpu_top.sv
module bpu_top import bpu_pkg::*; #(
    parameter int BM_INDEX_BITS  = 9,
    parameter int BTB_INDEX_BITS = 8,
    parameter int RAS_DEPTH      = 64,
    parameter int HIST_WIDTH     = 16
) (
    input  logic                  clk,
    input  logic                  rst,
    input  addr_t                 if_pc_i,
    input  inst_u                 if_inst_i,
    input  logic                  ex_valid_i,
    input  logic                  ex_taken_i,
    input  addr_t                 ex_pc_i,
    input  addr_t                 ex_target_i,
    input  inst_u                 ex_inst_i,
    input  logic                  id_push_i,
    input  addr_t                 id_push_addr_i,
    output logic                  branch_o,
    output logic                  pdt_taken_o,
    output addr_t                 pdt_pc_o,
    output logic [HIST_WIDTH-1:0] history_o
);

    logic                  if_branch, if_jal, if_jalr, if_ret;
    addr_t                 if_b_imm, if_j_imm;
    logic                  ex_jalr, ex_ret, ras_pop, btb_wr;
    logic                  bm_taken, btb_hit, ras_empty;
    addr_t                 btb_target, ras_top;
    logic [HIST_WIDTH-1:0] hist_q;

    inst_predecode u_if_dec (
        .inst_i(if_inst_i), .is_branch_o(if_branch), .is_jal_o(if_jal),
        .is_jalr_o(if_jalr), .is_ret_o(if_ret), .b_imm_o(if_b_imm), .j_imm_o(if_j_imm)
    );

    // ex side only needs the jalr class
    inst_predecode u_ex_dec (
        .inst_i(ex_inst_i), .is_branch_o(), .is_jal_o(), .is_jalr_o(ex_jalr),
        .is_ret_o(), .b_imm_o(), .j_imm_o()
    );

    // looser return match in ex on opcode and rs1 only
    assign ex_ret  = ex_jalr && ((ex_inst_i.i_fmt.rs1 == REG_RA)
                              || (ex_inst_i.i_fmt.rs1 == REG_T0));
    assign ras_pop = ex_valid_i && ex_taken_i && ex_ret;
    assign btb_wr  = ex_valid_i && ex_taken_i;

    bimodal_predictor #(.BM_INDEX_BITS(BM_INDEX_BITS)) u_bimodal (
        .clk(clk), .rst(rst), .rd_pc_i(if_pc_i), .pdt_taken_o(bm_taken),
        .upd_i(ex_valid_i), .upd_taken_i(ex_taken_i), .upd_pc_i(ex_pc_i)
    );

    branch_target_buffer #(.BTB_INDEX_BITS(BTB_INDEX_BITS)) u_btb (
        .clk(clk), .rst(rst), .rd_pc_i(if_pc_i), .hit_o(btb_hit), .target_o(btb_target),
        .wr_i(btb_wr), .wr_pc_i(ex_pc_i), .wr_target_i(ex_target_i)
    );

    return_address_stack #(.RAS_DEPTH(RAS_DEPTH)) u_ras (
        .clk(clk), .rst(rst), .push_i(id_push_i), .push_addr_i(id_push_addr_i),
        .pop_i(ras_pop), .empty_o(ras_empty), .top_o(ras_top)
    );

    always_comb begin
        branch_o    = if_branch || if_jal || if_jalr;
        pdt_taken_o = 1'b0;
        pdt_pc_o    = if_pc_i + 32'd4;
        if (if_ret) begin
            if (id_push_i) begin // call in id this cycle bypasses the stack
                pdt_taken_o = 1'b1;
                pdt_pc_o    = id_push_addr_i;
            end else if (!ras_empty) begin
                pdt_taken_o = 1'b1;
                pdt_pc_o    = ras_top;
            end
        end else if (if_jal) begin
            pdt_taken_o = 1'b1;
            pdt_pc_o    = btb_hit ? btb_target : if_pc_i + if_j_imm;
        end else if (if_branch) begin
            pdt_taken_o = bm_taken;
            if (bm_taken) begin
                pdt_pc_o = btb_hit ? btb_target : if_pc_i + if_b_imm;
            end
        end else if (if_jalr && btb_hit) begin
            pdt_taken_o = 1'b1; // indirect target only known from the btb
            pdt_pc_o    = btb_target;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            hist_q <= '0;
        end else if (ex_valid_i) begin
            hist_q <= {hist_q[HIST_WIDTH-2:0], ex_taken_i}; // newest at bit 0
        end
    end

    assign history_o = hist_q;

endmodule

// File: logic/branch_target_buffer.sv
module branch_target_buffer import bpu_pkg::*; #(
    parameter int BTB_INDEX_BITS = 8
) (
    input  logic  clk,
    input  logic  rst,
    input  addr_t rd_pc_i,
    output logic  hit_o,
    output addr_t target_o,
    input  logic  wr_i,
    input  addr_t wr_pc_i,
    input  addr_t wr_target_i
);

    localparam int ENTRIES  = 1 << BTB_INDEX_BITS;
    localparam int TAG_LSB  = BTB_INDEX_BITS + 2;
    localparam int TAG_BITS = XLEN - TAG_LSB; // everything above the index

    logic [TAG_BITS-1:0]       tag_q [ENTRIES];
    addr_t                     target_q [ENTRIES];
    logic [ENTRIES-1:0]        valid_q;

    logic [BTB_INDEX_BITS-1:0] rd_idx;
    logic [BTB_INDEX_BITS-1:0] wr_idx;
    logic [TAG_BITS-1:0]       rd_tag;
    logic [TAG_BITS-1:0]       wr_tag;

    // word aligned index
    assign rd_idx = rd_pc_i[TAG_LSB-1:2];
    assign rd_tag = rd_pc_i[XLEN-1:TAG_LSB];
    assign wr_idx = wr_pc_i[TAG_LSB-1:2];
    assign wr_tag = wr_pc_i[XLEN-1:TAG_LSB];

    assign hit_o    = valid_q[rd_idx] && (tag_q[rd_idx] == rd_tag);
    assign target_o = target_q[rd_idx];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid_q <= '0;
        end else if (wr_i) begin
            valid_q[wr_idx] <= 1'b1;
        end
    end

    // a write simply overwrites the entry
    always_ff @(posedge clk) begin
        if (wr_i) begin
            tag_q[wr_idx]    <= wr_tag;
            target_q[wr_idx] <= wr_target_i;
        end
    end

endmodule

// File: logic/inst_predecode.sv
module inst_predecode import bpu_pkg::*; (
    input  inst_u inst_i,
    output logic  is_branch_o,
    output logic  is_jal_o,
    output logic  is_jalr_o,
    output logic  is_ret_o,
    output addr_t b_imm_o,
    output addr_t j_imm_o
);

    logic [6:0] opcode;
    logic       rs1_link;
    logic       rd_zero;

    // opcode sits at the same place in every layout
    assign opcode = inst_i.i_fmt.opcode;

    assign is_branch_o = (opcode == OP_BRANCH);
    assign is_jal_o    = (opcode == OP_JAL);
    assign is_jalr_o   = (opcode == OP_JALR);

    assign rs1_link = (inst_i.i_fmt.rs1 == REG_RA) || (inst_i.i_fmt.rs1 == REG_T0);
    assign rd_zero  = (inst_i.i_fmt.rd == 5'd0);

    // jalr x0, 0(ra) or 0(t0)
    assign is_ret_o = is_jalr_o && rd_zero && rs1_link && (inst_i.i_fmt.imm12 == 12'd0);

    // b-type offset with bit 0 always zero
    assign b_imm_o = {
        {(XLEN-12){inst_i.b_fmt.imm12}},
        inst_i.b_fmt.imm11,
        inst_i.b_fmt.imm10_5,
        inst_i.b_fmt.imm4_1,
        1'b0
    };

    // j-type offset
    assign j_imm_o = {
        {(XLEN-20){inst_i.j_fmt.imm20}},
        inst_i.j_fmt.imm19_12,
        inst_i.j_fmt.imm11,
        inst_i.j_fmt.imm10_1,
        1'b0
    };

endmodule

// File: logic/return_address_stack.sv
module return_address_stack import bpu_pkg::*; #(
    parameter int RAS_DEPTH = 64
) (
    input  logic  clk,
    input  logic  rst,
    input  logic  push_i,
    input  addr_t push_addr_i,
    input  logic  pop_i,
    output logic  empty_o,
    output addr_t top_o
);

    localparam int IDX_BITS = $clog2(RAS_DEPTH);
    localparam int PTR_BITS = $clog2(RAS_DEPTH + 1); // must hold the full count

    addr_t               stack_q [RAS_DEPTH];
    logic [PTR_BITS-1:0] sp_q;     // next free slot
    logic [PTR_BITS-1:0] sp_pop;   // pointer once the pop is applied
    logic [PTR_BITS-1:0] sp_top;
    logic [IDX_BITS-1:0] top_idx;
    logic [IDX_BITS-1:0] push_idx;
    logic                do_pop;
    logic                do_push;

    assign empty_o = (sp_q == '0);

    // pop of an empty stack is ignored
    assign do_pop = pop_i && !empty_o;
    assign sp_pop = do_pop ? sp_q - PTR_BITS'(1) : sp_q;

    // push only checked for room after the pop
    // so pop and push together replace the top
    assign do_push  = push_i && (sp_pop != PTR_BITS'(RAS_DEPTH));
    assign push_idx = IDX_BITS'(sp_pop);

    // top entry is only meaningful when not empty
    assign sp_top  = sp_q - PTR_BITS'(1);
    assign top_idx = IDX_BITS'(sp_top);
    assign top_o   = stack_q[top_idx];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            sp_q <= '0;
        end else begin
            sp_q <= sp_pop + PTR_BITS'(do_push);
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            stack_q[push_idx] <= push_addr_i;
        end
    end

endmodule

// File: run.sh
#!/bin/sh
# build and run the bpu testbench, fail if the log holds the fail message
verilator --binary --assert --top-module tb_bpu -f tb.f -o tb_bpu > build.log 2>&1 \
    || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/tb_bpu +verilator+error+limit+100 > sim.log 2>&1 \
    || echo "FAIL: see errors above" >> sim.log
cat sim.log
grep -q "FAIL: see errors above" sim.log && exit 1 || exit 0

// File: tb.f
logic/bpu_pkg.sv
logic/inst_predecode.sv
logic/bimodal_predictor.sv
logic/branch_target_buffer.sv
logic/return_address_stack.sv
logic/bpu_top.sv
verif/bpu_assertions.sv
verif/bpu_checker.sv
verif/tb_bpu.sv

// File: verif/bpu_assertions.sv
module bpu_assertions import bpu_pkg::*; #(
    parameter int HIST_WIDTH = 16
) (
    input logic                  clk,
    input logic                  rst,
    input logic                  ex_valid_i,
    input logic                  branch_i,
    input logic                  pdt_taken_i,
    input addr_t                 pdt_pc_i,
    input logic [HIST_WIDTH-1:0] history_i
);

    int fail_count = 0; // read by the testbench at the end

    a_known: assert property (@(posedge clk) disable iff (rst)
        !$isunknown({branch_i, pdt_taken_i, pdt_pc_i, history_i}))
    else begin
        $error("prediction outputs unknown");
        fail_count++;
    end

    // a taken prediction only for a control instruction
    a_taken_branch: assert property (@(posedge clk) disable iff (rst)
        pdt_taken_i |-> branch_i)
    else begin
        $error("pdt_taken_o without branch_o");
        fail_count++;
    end

    a_hist_strobe: assert property (@(posedge clk) disable iff (rst)
        !$stable(history_i) |-> $past(ex_valid_i))
    else begin
        $error("history_o changed without ex_valid_i");
        fail_count++;
    end

endmodule

bind bpu_top bpu_assertions #(.HIST_WIDTH(HIST_WIDTH)) u_bpu_assertions (
    .clk(clk), .rst(rst), .ex_valid_i(ex_valid_i), .branch_i(branch_o),
    .pdt_taken_i(pdt_taken_o), .pdt_pc_i(pdt_pc_o), .history_i(history_o)
);

// File: verif/bpu_checker.sv
module bpu_checker import bpu_pkg::*; #(
    parameter int HIST_WIDTH = 16
) (
    input  logic                  clk,
    input  logic                  check_i,
    input  logic                  done_i,
    input  int                    test_num_i,
    input  logic                  exp_branch_i,
    input  logic                  exp_taken_i,
    input  addr_t                 exp_pc_i,
    input  logic [HIST_WIDTH-1:0] exp_hist_i,
    input  logic                  branch_i,
    input  logic                  pdt_taken_i,
    input  addr_t                 pdt_pc_i,
    input  logic [HIST_WIDTH-1:0] history_i,
    output int                    error_count_o
);

    int cur_test = 0;    // 0 until the first vector
    int test_errors = 0;
    int tests_done = 0;
    int tests_failed = 0;

    initial error_count_o = 0;

    task automatic close_test();
        tests_done++;
        if (test_errors == 0) begin
            $display("test %0d passed", cur_test);
        end else begin
            tests_failed++;
            $display("test %0d failed with %0d errors", cur_test, test_errors);
        end
    endtask

    task automatic compare(input string name, input addr_t expected, input addr_t actual);
        if (actual !== expected) begin
            $display("error at %0t: test %0d %s expected %0h got %0h",
                     $time, cur_test, name, expected, actual);
            test_errors++;
            error_count_o++;
        end
    endtask

    // outputs settle well before the falling edge
    always @(negedge clk) begin
        if (check_i) begin
            if (test_num_i != cur_test) begin
                if (cur_test != 0) begin
                    close_test();
                end
                cur_test = test_num_i;
                test_errors = 0;
            end
            compare("branch_o", addr_t'(exp_branch_i), addr_t'(branch_i));
            compare("pdt_taken_o", addr_t'(exp_taken_i), addr_t'(pdt_taken_i));
            compare("pdt_pc_o", exp_pc_i, pdt_pc_i);
            compare("history_o", addr_t'(exp_hist_i), addr_t'(history_i));
        end
    end

    always @(posedge done_i) begin
        if (cur_test != 0) begin
            close_test(); // last test has no successor
        end
        $display("tests %0d, failed %0d, errors %0d", tests_done, tests_failed, error_count_o);
    end

endmodule

// File: verif/bpu_vectors.txt
# test ex_valid ex_taken ex_pc ex_target ex_inst id_push id_addr if_pc if_inst
# exp_branch exp_taken exp_pc exp_hist (single bits and test in decimal, the rest hex)
1 0 0 00000000 00000000 00000013 0 00000000 00001000 00000013 0 0 00001004 0000
1 0 0 00000000 00000000 00000013 0 00000000 00001010 00000863 1 0 00001014 0000
2 1 1 00002000 00002040 00000863 0 00000000 00002000 00000863 1 0 00002004 0000
2 1 1 00002000 00002040 00000863 0 00000000 00002000 00000863 1 1 00002040 0001
2 0 0 00000000 00000000 00000013 0 00000000 00002000 00000863 1 1 00002040 0003
2 1 1 00002400 00002480 00000863 0 00000000 00002000 00000863 1 1 00002040 0003
2 0 0 00000000 00000000 00000013 0 00000000 00002000 00000863 1 1 00002010 0007
2 0 0 00000000 00000000 00000013 0 00000000 00002400 fe001ce3 1 1 00002480 0007
2 1 0 00002000 00002004 00000863 0 00000000 00002000 00000863 1 1 00002010 0007
2 1 0 00002000 00002004 00000863 0 00000000 00002000 00000863 1 1 00002010 000e
2 0 0 00000000 00000000 00000013 0 00000000 00002000 00000863 1 0 00002004 001c
3 0 0 00000000 00000000 00000013 0 00000000 00004000 100000ef 1 1 00004100 001c
3 1 1 00004000 00004200 100000ef 0 00000000 00004000 100000ef 1 1 00004100 001c
3 0 0 00000000 00000000 00000013 0 00000000 00004000 100000ef 1 1 00004200 0039
4 0 0 00000000 00000000 00000013 0 00000000 00005000 00008067 1 0 00005004 0039
4 0 0 00000000 00000000 00000013 1 00006004 00001000 00000013 0 0 00001004 0039
4 0 0 00000000 00000000 00000013 1 00007008 00005000 00008067 1 1 00007008 0039
4 0 0 00000000 00000000 00000013 0 00000000 00005000 00008067 1 1 00007008 0039
4 1 1 00005000 00007008 00008067 0 00000000 00005000 00008067 1 1 00007008 0039
4 0 0 00000000 00000000 00000013 0 00000000 00005000 00008067 1 1 00006004 0073
4 1 1 00005000 00006004 00008067 0 00000000 00005000 00008067 1 1 00006004 0073
4 0 0 00000000 00000000 00000013 0 00000000 00005000 00008067 1 0 00005004 00e7
4 0 0 00000000 00000000 00000013 1 00008888 00005000 00008067 1 1 00008888 00e7
5 0 0 00000000 00000000 00000013 0 00000000 00006000 00050067 1 0 00006004 00e7
5 1 1 00006000 00009000 00050067 0 00000000 00006000 00050067 1 0 00006004 00e7
5 0 0 00000000 00000000 00000013 0 00000000 00006000 00050067 1 1 00009000 01cf
5 0 0 00000000 00000000 00000013 0 00000000 00005000 00008067 1 1 00008888 01cf
6 1 1 00007000 00007100 00000863 0 00000000 00001000 00000013 0 0 00001004 01cf
6 1 0 00007000 00007004 00000863 0 00000000 00001000 00000013 0 0 00001004 039f
6 1 1 00007000 00007100 00000863 0 00000000 00001000 00000013 0 0 00001004 073e
6 1 1 00007000 00007100 00000863 0 00000000 00001000 00000013 0 0 00001004 0e7d
6 0 0 00000000 00000000 00000013 0 00000000 00001000 00000013 0 0 00001004 1cfb

// File: verif/tb_bpu.sv
module tb_bpu import bpu_pkg::*; ();

    localparam int HIST_WIDTH = 16;
    localparam int MAX_CYCLES = 200;

    logic clk, rst;
    addr_t if_pc, ex_pc, ex_target, id_push_addr, pdt_pc;
    inst_u if_inst, ex_inst;
    logic ex_valid, ex_taken, id_push, branch, pdt_taken;
    logic [HIST_WIDTH-1:0] history;

    // one parsed vector line
    int v_test;
    logic v_ex_valid, v_ex_taken, v_id_push, exp_branch, exp_taken;
    addr_t v_ex_pc, v_ex_target, v_ex_inst, v_id_addr, v_if_pc, v_if_inst, exp_pc;
    logic [HIST_WIDTH-1:0] exp_hist;

    logic check, done, timed_out;
    int fd, cycles, bad_lines, errors, fields;
    string line;

    bpu_top #(.HIST_WIDTH(HIST_WIDTH)) i_dut (
        .clk(clk), .rst(rst), .if_pc_i(if_pc), .if_inst_i(if_inst),
        .ex_valid_i(ex_valid), .ex_taken_i(ex_taken), .ex_pc_i(ex_pc),
        .ex_target_i(ex_target), .ex_inst_i(ex_inst), .id_push_i(id_push),
        .id_push_addr_i(id_push_addr), .branch_o(branch), .pdt_taken_o(pdt_taken),
        .pdt_pc_o(pdt_pc), .history_o(history)
    );

    bpu_checker #(.HIST_WIDTH(HIST_WIDTH)) u_checker (
        .clk(clk), .check_i(check), .done_i(done), .test_num_i(v_test),
        .exp_branch_i(exp_branch), .exp_taken_i(exp_taken), .exp_pc_i(exp_pc),
        .exp_hist_i(exp_hist), .branch_i(branch), .pdt_taken_i(pdt_taken),
        .pdt_pc_i(pdt_pc), .history_i(history), .error_count_o(errors)
    );

    always #50 clk = ~clk;

    task automatic set_idle();
        if_pc = '0;
        if_inst = 32'h0000_0013; // nop
        ex_valid = 1'b0;
        ex_taken = 1'b0;
        ex_pc = '0;
        ex_target = '0;
        ex_inst = 32'h0000_0013;
        id_push = 1'b0;
        id_push_addr = '0;
    endtask

    task automatic apply_vector();
        ex_valid = v_ex_valid;
        ex_taken = v_ex_taken;
        ex_pc = v_ex_pc;
        ex_target = v_ex_target;
        ex_inst = v_ex_inst;
        id_push = v_id_push;
        id_push_addr = v_id_addr;
        if_pc = v_if_pc;
        if_inst = v_if_inst;
    endtask

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        check = 1'b0;
        done = 1'b0;
        timed_out = 1'b0;
        v_test = 0;
        cycles = 0;
        bad_lines = 0;
        set_idle();
        fd = $fopen("verif/bpu_vectors.txt", "r");
        if (fd == 0) begin
            $display("could not open verif/bpu_vectors.txt");
        end
        repeat (10) @(posedge clk);
        #1;
        rst = 1'b0;
        // one line per cycle up to the cycle limit
        while (fd != 0 && !timed_out && $fgets(line, fd) != 0) begin
            if (line.len() > 1 && line.getc(0) != "#") begin
                fields = $sscanf(line, "%d %d %d %h %h %h %d %h %h %h %d %d %h %h",
                                 v_test, v_ex_valid, v_ex_taken, v_ex_pc, v_ex_target,
                                 v_ex_inst, v_id_push, v_id_addr, v_if_pc, v_if_inst,
                                 exp_branch, exp_taken, exp_pc, exp_hist);
                if (fields != 14) begin
                    $display("malformed vector line: %s", line);
                    bad_lines++;
                end else begin
                    apply_vector();
                    check = 1'b1;
                    @(posedge clk);
                    #1;
                    cycles++;
                    if (cycles >= MAX_CYCLES) begin
                        timed_out = 1'b1;
                    end
                end
            end
        end
        check = 1'b0;
        set_idle();
        if (fd != 0) begin
            $fclose(fd);
        end
        if (timed_out) begin
            $display("timeout: vector file not finished");
        end
        if (cycles == 0) begin
            $display("no vectors were applied");
        end
        done = 1'b1;
        #1;
        if (errors == 0 && bad_lines == 0 && !timed_out && cycles > 0
            && i_dut.u_bpu_assertions.fail_count == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule
